//--- src/exCfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Datapath width of the execute stage
`define EX_DATA_W 16

// Full five-bit instruction class codes
`define EX_OP_LBI  5'b11000
`define EX_OP_SLBI 5'b10010
`define EX_OP_BTR  5'b11001
`define EX_OP_JAL  5'b00110
`define EX_OP_JALR 5'b00111

// Upper three bits of the class code
// Branches use the low bits for the condition, set ops for the compare
`define EX_CLASS_BRANCH 3'b011
`define EX_CLASS_SET    3'b111

`endif

//--- src/exPkg.sv
`include "exCfg.svh"

package exPkg;

    // Word carried for operands, pc and result
    typedef logic [`EX_DATA_W-1:0] dataT;

    // Instruction class code as it leaves the ID/EX latch
    typedef logic [4:0] instrOpT;

    // Forwarding select, one per ALU operand
    typedef enum logic [1:0] {
        fwdNone    = 2'b00,
        fwdMemWb   = 2'b01,
        fwdExMem   = 2'b10,
        fwdMemData = 2'b11
    } fwdSelT;

    // ALU operation from the decoder
    typedef enum logic [2:0] {
        opRll = 3'b000,
        opSll = 3'b001,
        opRor = 3'b010,
        opSrl = 3'b011,
        opAdd = 3'b100,
        opAnd = 3'b101,
        opOr  = 3'b110,
        opXor = 3'b111
    } aluOperT;

    // Set condition, taken from the two low class bits
    typedef enum logic [1:0] {
        setEq = 2'b00,
        setLt = 2'b01,
        setLe = 2'b10,
        setCo = 2'b11
    } setCondT;

endpackage

//--- src/exCtrlIf.sv
`timescale 1ns/1ps

interface exCtrlIf;
    import exPkg::*;

    // One-hot style instruction class decode
    logic    isLbi;
    logic    isSlbi;
    logic    isBranch;
    logic    isSet;
    logic    isBtr;
    logic    isLink;
    setCondT setCond;
    // Load enable for the EX/MEM register
    logic    capture;

    modport ctrl (
        output isLbi, isSlbi, isBranch, isSet, isBtr, isLink, setCond, capture
    );

    modport opnd (
        input isLbi, isSlbi, isBranch
    );

    modport res (
        input isSet, isBtr, isLink, setCond, capture
    );

endinterface

//--- src/execControl.sv
`timescale 1ns/1ps
`include "exCfg.svh"

module execControl (
    input  logic           clk,
    input  logic           rst,
    input  logic           inValid,
    input  exPkg::instrOpT aluOp,
    exCtrlIf.ctrl          ctrl,
    output logic           outValid
);
    import exPkg::*;

    logic [2:0] upperClass;
    logic       isJal;
    logic       isJalr;

    assign upperClass = aluOp[4:2];

    // Exact class matches
    always_comb begin
        ctrl.isLbi  = (aluOp == `EX_OP_LBI);
        ctrl.isSlbi = (aluOp == `EX_OP_SLBI);
        ctrl.isBtr  = (aluOp == `EX_OP_BTR);
    end

    // Both link forms pass pc on as the result
    assign isJal       = (aluOp == `EX_OP_JAL);
    assign isJalr      = (aluOp == `EX_OP_JALR);
    assign ctrl.isLink = isJal | isJalr;

    // Group matches on the upper three bits
    // beqz, bnez, bltz and bgez share one group
    assign ctrl.isBranch = (upperClass == `EX_CLASS_BRANCH);
    // seq, slt, sle and sco share the other
    assign ctrl.isSet    = (upperClass == `EX_CLASS_SET);

    // Compare type sits in the two low bits
    assign ctrl.setCond = setCondT'(aluOp[1:0]);

    // Every valid instruction is taken, memory never pushes back
    assign ctrl.capture = inValid;

    // Valid bit travelling alongside the EX/MEM payload
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

endmodule

//--- src/operandSelect.sv
`timescale 1ns/1ps

module operandSelect (
    input  exPkg::dataT   readData1,
    input  exPkg::dataT   readData2,
    input  exPkg::dataT   immVal,
    input  exPkg::dataT   aluResExMem,
    input  exPkg::dataT   aluResMemWb,
    input  exPkg::dataT   memDataMemWb,
    input  logic          aluSrc,
    input  exPkg::fwdSelT forwardA,
    input  exPkg::fwdSelT forwardB,
    input  logic          invA,
    input  logic          invB,
    exCtrlIf.opnd         ctrl,
    output exPkg::dataT   opA,
    output exPkg::dataT   opB
);
    import exPkg::*;

    dataT preA;
    dataT preB;
    dataT srcB;
    dataT fwdA;
    dataT fwdB;

    // Pick between the local operand and the three bypass paths
    function automatic dataT forwardMux(input fwdSelT sel, input dataT localVal);
        dataT picked;
        case (sel)
            fwdMemWb:   picked = aluResMemWb;
            fwdExMem:   picked = aluResExMem;
            fwdMemData: picked = memDataMemWb;
            default:    picked = localVal;
        endcase
        return picked;
    endfunction

    // Operand A: lbi adds to zero, slbi moves Rs up a byte first
    always_comb begin
        if (ctrl.isLbi) begin
            preA = '0;
        end else if (ctrl.isSlbi) begin
            preA = readData2 << 8;
        end else begin
            preA = readData2;
        end
    end

    // Operand B: immediate or register, cleared for branches
    assign srcB = aluSrc ? immVal : readData1;
    assign preB = ctrl.isBranch ? '0 : srcB;

    always_comb begin
        fwdA = forwardMux(forwardA, preA);
        fwdB = forwardMux(forwardB, preB);
    end

    // Inversion is applied to the forwarded values
    assign opA = invA ? ~fwdA : fwdA;
    assign opB = invB ? ~fwdB : fwdB;

endmodule

//--- src/alu.sv
`timescale 1ns/1ps
`include "exCfg.svh"

module alu (
    input  exPkg::dataT    inA,
    input  exPkg::dataT    inB,
    input  logic           cIn,
    input  logic           sign,
    input  exPkg::aluOperT oper,
    output exPkg::dataT    aluOut,
    output logic           zero,
    output logic           ltz,
    output logic           ovf
);
    import exPkg::*;

    localparam int DataW = `EX_DATA_W;

    logic [3:0]         shAmt;
    logic [2*DataW-1:0] doubled;
    dataT               rotLeft;
    dataT               rotRight;
    logic [DataW:0]     sumWide;
    dataT               sum;
    logic               carryOut;
    logic               signedOvf;
    logic               isAdd;

    // Shift count comes from the low nibble of operand B
    assign shAmt = inB[3:0];

    // Rotates done on a doubled copy of operand A
    assign doubled  = {inA, inA};
    assign rotLeft  = dataT'(doubled >> (DataW - shAmt));
    assign rotRight = dataT'(doubled >> shAmt);

    // Adder with carry-in, carry-out kept in the top bit
    assign sumWide  = {1'b0, inA} + {1'b0, inB} + {{DataW{1'b0}}, cIn};
    assign sum      = sumWide[DataW-1:0];
    assign carryOut = sumWide[DataW];

    // Signed overflow when like-signed inputs give the other sign
    assign signedOvf = (inA[DataW-1] == inB[DataW-1]) && (sum[DataW-1] != inA[DataW-1]);

    always_comb begin
        aluOut = inA;
        case (oper)
            opRll: aluOut = rotLeft;
            opSll: aluOut = inA << shAmt;
            opRor: aluOut = rotRight;
            opSrl: aluOut = inA >> shAmt;
            opAdd: aluOut = sum;
            opAnd: aluOut = inA & inB;
            opOr:  aluOut = inA | inB;
            opXor: aluOut = inA ^ inB;
            default: aluOut = inA;
        endcase
    end

    assign isAdd = (oper == opAdd);

    assign zero = (aluOut == '0);

    // Unsigned compare reads a missing carry as a borrow
    assign ltz = sign ? aluOut[DataW-1] : ~carryOut;

    // Only add reports overflow
    assign ovf = isAdd & (sign ? signedOvf : carryOut);

endmodule

//--- src/resultSelect.sv
`timescale 1ns/1ps

module resultSelect (
    input  logic        clk,
    input  logic        rst,
    input  exPkg::dataT aluOut,
    input  exPkg::dataT readData2,
    input  exPkg::dataT pc,
    input  logic        zero,
    input  logic        ltz,
    input  logic        ovf,
    exCtrlIf.res        ctrl,
    output exPkg::dataT result,
    output logic        zeroQ,
    output logic        ltzQ,
    output logic        errQ
);
    import exPkg::*;

    logic setBit;
    dataT setWord;
    dataT btrWord;
    dataT nextResult;

    function automatic dataT reverseBits(input dataT value);
        dataT flipped;
        for (int i = 0; i < $bits(dataT); i++) begin
            flipped[i] = value[$bits(dataT)-1-i];
        end
        return flipped;
    endfunction

    // Compare outcome from the ALU flags
    always_comb begin
        case (ctrl.setCond)
            setEq:   setBit = zero;
            setLt:   setBit = ltz;
            setLe:   setBit = zero | ltz;
            setCo:   setBit = ovf;
            default: setBit = 1'b0;
        endcase
    end

    assign setWord = dataT'(setBit);
    assign btrWord = reverseBits(readData2);

    // Link wins over btr, btr over set, set over the plain ALU value
    always_comb begin
        if (ctrl.isLink) begin
            nextResult = pc;
        end else if (ctrl.isBtr) begin
            nextResult = btrWord;
        end else if (ctrl.isSet) begin
            nextResult = setWord;
        end else begin
            nextResult = aluOut;
        end
    end

    // EX/MEM register, holds while no instruction is valid
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            zeroQ  <= 1'b0;
            ltzQ   <= 1'b0;
            errQ   <= 1'b0;
        end else if (ctrl.capture) begin
            result <= nextResult;
            zeroQ  <= zero;
            ltzQ   <= ltz;
            errQ   <= ovf;
        end
    end

endmodule

//--- src/exStage.sv
`timescale 1ns/1ps

module exStage (
    input  logic           clk,
    input  logic           rst,
    input  logic           inValid,
    input  exPkg::instrOpT aluOp,
    input  exPkg::aluOperT aluControl,
    input  logic           aluSrc,
    input  logic           invA,
    input  logic           invB,
    input  logic           cIn,
    input  logic           sign,
    input  exPkg::fwdSelT  forwardA,
    input  exPkg::fwdSelT  forwardB,
    input  exPkg::dataT    readData1,
    input  exPkg::dataT    readData2,
    input  exPkg::dataT    immVal,
    input  exPkg::dataT    pc,
    input  exPkg::dataT    aluResExMem,
    input  exPkg::dataT    aluResMemWb,
    input  exPkg::dataT    memDataMemWb,
    output exPkg::dataT    result,
    output logic           zero,
    output logic           ltz,
    output logic           err,
    output logic           outValid
);
    import exPkg::*;

    dataT opA;
    dataT opB;
    dataT aluOut;
    logic aluZero;
    logic aluLtz;
    logic aluOvf;

    exCtrlIf ctrlBus ();

    execControl uControl (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .aluOp    (aluOp),
        .ctrl     (ctrlBus.ctrl),
        .outValid (outValid)
    );

    operandSelect uOperands (
        .readData1    (readData1),
        .readData2    (readData2),
        .immVal       (immVal),
        .aluResExMem  (aluResExMem),
        .aluResMemWb  (aluResMemWb),
        .memDataMemWb (memDataMemWb),
        .aluSrc       (aluSrc),
        .forwardA     (forwardA),
        .forwardB     (forwardB),
        .invA         (invA),
        .invB         (invB),
        .ctrl         (ctrlBus.opnd),
        .opA          (opA),
        .opB          (opB)
    );

    alu uAlu (
        .inA    (opA),
        .inB    (opB),
        .cIn    (cIn),
        .sign   (sign),
        .oper   (aluControl),
        .aluOut (aluOut),
        .zero   (aluZero),
        .ltz    (aluLtz),
        .ovf    (aluOvf)
    );

    resultSelect uResult (
        .clk       (clk),
        .rst       (rst),
        .aluOut    (aluOut),
        .readData2 (readData2),
        .pc        (pc),
        .zero      (aluZero),
        .ltz       (aluLtz),
        .ovf       (aluOvf),
        .ctrl      (ctrlBus.res),
        .result    (result),
        .zeroQ     (zero),
        .ltzQ      (ltz),
        .errQ      (err)
    );

endmodule

//--- tb/exStageTb.sv
`timescale 1ns/1ps

module exStageTb;
    import exPkg::*;

    localparam int NumFields = 23;

    logic    clk;
    logic    rst;
    logic    inValid;
    instrOpT aluOp;
    aluOperT aluControl;
    logic    aluSrc;
    logic    invA;
    logic    invB;
    logic    cIn;
    logic    sign;
    fwdSelT  forwardA;
    fwdSelT  forwardB;
    dataT    readData1;
    dataT    readData2;
    dataT    immVal;
    dataT    pc;
    dataT    aluResExMem;
    dataT    aluResMemWb;
    dataT    memDataMemWb;
    dataT    result;
    logic    zero;
    logic    ltz;
    logic    err;
    logic    outValid;

    // Vector lines kept as text, parsed one at a time
    string vecLines[$];
    int    errCount = 0;
    int    testCount = 0;
    int    cycles = 0;
    int    cycleLimit = 20;

    exStage UUT (
        .clk          (clk),
        .rst          (rst),
        .inValid      (inValid),
        .aluOp        (aluOp),
        .aluControl   (aluControl),
        .aluSrc       (aluSrc),
        .invA         (invA),
        .invB         (invB),
        .cIn          (cIn),
        .sign         (sign),
        .forwardA     (forwardA),
        .forwardB     (forwardB),
        .readData1    (readData1),
        .readData2    (readData2),
        .immVal       (immVal),
        .pc           (pc),
        .aluResExMem  (aluResExMem),
        .aluResMemWb  (aluResMemWb),
        .memDataMemWb (memDataMemWb),
        .result       (result),
        .zero         (zero),
        .ltz          (ltz),
        .err          (err),
        .outValid     (outValid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, vectors did not complete", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic checkData(input string name, input dataT expVal, input dataT actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s: expected %h, got %h", name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s: expected %h, got %h", name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic clearInputs();
        rst          = 1'b1;
        inValid      = 1'b0;
        aluOp        = '0;
        aluControl   = opRll;
        aluSrc       = 1'b0;
        invA         = 1'b0;
        invB         = 1'b0;
        cIn          = 1'b0;
        sign         = 1'b0;
        forwardA     = fwdNone;
        forwardB     = fwdNone;
        readData1    = '0;
        readData2    = '0;
        immVal       = '0;
        pc           = '0;
        aluResExMem  = '0;
        aluResMemWb  = '0;
        memDataMemWb = '0;
    endtask

    task automatic runVector(input string line);
        string      label;
        logic       rstV, validV, srcV, invAV, invBV, cInV, signV;
        logic [4:0] opV;
        logic [2:0] operV;
        logic [1:0] fwdAV, fwdBV;
        dataT       rd1V, rd2V, immV, pcV, exMemV, memWbV, memDataV;
        dataT       expRes;
        logic       expZero, expLtz, expErr, expValid;
        int         n;
        int         errBefore;
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    label, rstV, validV, opV, operV, srcV, invAV, invBV, cInV, signV,
                    fwdAV, fwdBV, rd1V, rd2V, immV, pcV, exMemV, memWbV, memDataV,
                    expRes, expZero, expLtz, expErr);
        if (n != NumFields) begin
            $display("Vector line has %0d fields instead of %0d: %s", n, NumFields, line);
            errCount++;
        end else begin
            @(negedge clk);
            rst          = rstV;
            inValid      = validV;
            aluOp        = opV;
            aluControl   = aluOperT'(operV);
            aluSrc       = srcV;
            invA         = invAV;
            invB         = invBV;
            cIn          = cInV;
            sign         = signV;
            forwardA     = fwdSelT'(fwdAV);
            forwardB     = fwdSelT'(fwdBV);
            readData1    = rd1V;
            readData2    = rd2V;
            immVal       = immV;
            pc           = pcV;
            aluResExMem  = exMemV;
            aluResMemWb  = memWbV;
            memDataMemWb = memDataV;
            @(posedge clk);
            #1;
            // Valid out only for an accepted instruction outside reset
            expValid  = ~rstV & validV;
            errBefore = errCount;
            checkData("result", expRes, result);
            checkFlag("zero", expZero, zero);
            checkFlag("ltz", expLtz, ltz);
            checkFlag("err", expErr, err);
            checkFlag("outValid", expValid, outValid);
            testCount++;
            if (errCount == errBefore) begin
                $display("%s ok", label);
            end else begin
                $display("%s mismatch", label);
            end
        end
    endtask

    initial begin
        string line;
        int    fd;
        clearInputs();
        fd = $fopen("tb/exInput.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/exInput.txt");
            errCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip blank lines and the column notes
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    vecLines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycleLimit = 4 * vecLines.size() + 20;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (vecLines[i]) begin
            runVector(vecLines[i]);
        end

        $display("Vectors run: %0d, errors: %0d", testCount, errCount);
        if (errCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tb/exInput.txt
# label rst inValid aluOp aluControl aluSrc invA invB cIn sign forwardA forwardB
# readData1 readData2 immVal pc aluResExMem aluResMemWb memDataMemWb, expected result zero ltz err
rll      0 1 10 0 0 0 0 0 1 0 0 0004 8001 0000 0000 0000 0000 0000 0018 0 0 0
sll      0 1 10 1 1 0 0 0 1 0 0 1234 00f1 0008 0000 0000 0000 0000 f100 0 1 0
ror      0 1 10 2 0 0 0 0 1 0 0 0004 0018 0000 0000 0000 0000 0000 8001 0 1 0
srl      0 1 10 3 0 0 0 0 1 0 0 001c f000 0000 0000 0000 0000 0000 000f 0 0 0
and      0 1 10 5 0 0 0 0 1 0 0 0f0f f0f0 0000 0000 0000 0000 0000 0000 1 0 0
or       0 1 10 6 0 0 0 0 1 0 0 000f f000 0000 0000 0000 0000 0000 f00f 0 1 0
xor      0 1 10 7 0 0 0 0 1 0 0 0f0f ffff 0000 0000 0000 0000 0000 f0f0 0 1 0
add      0 1 10 4 0 0 0 0 1 0 0 1111 1234 0000 0000 0000 0000 0000 2345 0 0 0
invA     0 1 10 5 0 1 0 0 1 0 0 0f0f 00ff 0000 0000 0000 0000 0000 0f00 0 0 0
subZero  0 1 10 4 0 0 1 1 1 0 0 0005 0005 0000 0000 0000 0000 0000 0000 1 0 0
subNeg   0 1 10 4 0 0 1 1 1 0 0 0005 0003 0000 0000 0000 0000 0000 fffe 0 1 0
subULt   0 1 10 4 0 0 1 1 0 0 0 0005 0003 0000 0000 0000 0000 0000 fffe 0 1 0
subUGe   0 1 10 4 0 0 1 1 0 0 0 0005 0007 0000 0000 0000 0000 0000 0002 0 0 1
addSOvf  0 1 10 4 0 0 0 0 1 0 0 0001 7fff 0000 0000 0000 0000 0000 8000 0 1 1
addUOvf  0 1 10 4 0 0 0 0 0 0 0 0002 ffff 0000 0000 0000 0000 0000 0001 0 0 1
lbi      0 1 18 4 1 0 0 0 1 0 0 0000 1234 00a5 0000 0000 0000 0000 00a5 0 0 0
slbi     0 1 12 6 1 0 0 0 1 0 0 0000 0012 0034 0000 0000 0000 0000 1234 0 0 0
beqz     0 1 0c 4 1 0 0 0 1 0 0 5555 0000 7777 0000 0000 0000 0000 0000 1 0 0
bltz     0 1 0e 4 0 0 0 0 1 0 0 5555 8000 0000 0000 0000 0000 0000 8000 0 1 0
seqT     0 1 1c 4 0 0 1 1 1 0 0 0009 0009 0000 0000 0000 0000 0000 0001 1 0 0
seqF     0 1 1c 4 0 0 1 1 1 0 0 0008 0009 0000 0000 0000 0000 0000 0000 0 0 0
sltT     0 1 1d 4 0 0 1 1 1 0 0 0003 fffe 0000 0000 0000 0000 0000 0001 0 1 0
sltF     0 1 1d 4 0 0 1 1 1 0 0 0003 0004 0000 0000 0000 0000 0000 0000 0 0 0
sleT     0 1 1e 4 0 0 1 1 1 0 0 0007 0007 0000 0000 0000 0000 0000 0001 1 0 0
sleF     0 1 1e 4 0 0 1 1 1 0 0 0007 0008 0000 0000 0000 0000 0000 0000 0 0 0
scoT     0 1 1f 4 0 0 0 0 0 0 0 0001 ffff 0000 0000 0000 0000 0000 0001 1 0 1
scoF     0 1 1f 4 0 0 0 0 0 0 0 0001 0001 0000 0000 0000 0000 0000 0000 0 1 0
btr      0 1 19 4 0 0 0 0 1 0 0 0000 00f1 0000 0000 0000 0000 0000 8f00 0 0 0
jal      0 1 06 4 0 0 0 0 1 0 0 0003 0002 0000 1230 0000 0000 0000 1230 0 0 0
jalr     0 1 07 4 0 0 0 0 1 0 0 0000 8000 0000 0abc 0000 0000 0000 0abc 0 1 0
hold     0 0 10 4 0 0 0 0 1 0 0 0001 0001 0000 0000 0000 0000 0000 0abc 0 1 0
reset    1 1 10 4 0 0 0 0 1 0 0 0001 0001 0000 0000 0000 0000 0000 0000 0 0 0
fwdWbEx  0 1 10 4 0 0 0 0 1 1 2 1000 4000 0000 0000 0100 0020 0003 0120 0 0 0
fwdExMd  0 1 10 4 0 0 0 0 1 2 3 1000 4000 0000 0000 0100 0020 0003 0103 0 0 0
fwdMdWb  0 1 10 4 0 0 0 0 1 3 1 1000 4000 0000 0000 0100 0020 0003 0023 0 0 0

//--- filelist.f
+incdir+src
src/exPkg.sv
src/exCtrlIf.sv
src/execControl.sv
src/operandSelect.sv
src/alu.sv
src/resultSelect.sv
src/exStage.sv
tb/exStageTb.sv

//--- Makefile
TB_TOP = exStageTb

.PHONY: all lint clean

all:
	verilator --binary --timing -f filelist.f --top-module $(TB_TOP) -o simv
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module exStage

clean:
	rm -rf obj_dir
